// File: bench/tb_board_ctrl.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

module tb_board_ctrl import bus_pkg::*, board_pkg::*; ();

  localparam int CLK_PERIOD       = 20;
  localparam int DRIVE_DELAY      = 2;
  localparam int RESET_CYCLES     = 2;
  localparam int NUM_ENTRIES      = 19;
  localparam int MAX_REQ          = 5;
  localparam int MAX_RSP          = 3;
  localparam int SYNC_CYCLES      = 4;  // Two sync flops, the edge flop and status.
  localparam int SETTLE_CYCLES    = 2;
  localparam int CYCLES_PER_ENTRY = 64;
  localparam int TIMEOUT_CYCLES   = NUM_ENTRIES * CYCLES_PER_ENTRY;

  logic                   gclk40;
  logic                   hard_reset;
  logic [`BMC_BYTE_W-1:0] rx_data_i;
  logic                   rx_strb_i;
  logic                   rx_busy_o;
  logic [`BMC_BYTE_W-1:0] tx_data_o;
  logic                   tx_strb_o;
  logic                   tx_busy_i;
  logic                   event_i;
  logic [`BMC_BYTE_W-1:0] sys_config_o;
  logic                   irq_o;

  // One row per command, request bytes and the expected results.
  logic [`BMC_BYTE_W-1:0] req_tab   [NUM_ENTRIES][MAX_REQ];
  int                     req_len   [NUM_ENTRIES];
  logic                   event_tab [NUM_ENTRIES];
  logic [`BMC_BYTE_W-1:0] rsp_tab   [NUM_ENTRIES][MAX_RSP];
  int                     rsp_len   [NUM_ENTRIES];
  logic [`BMC_BYTE_W-1:0] cfg_tab   [NUM_ENTRIES];
  logic                   irq_tab   [NUM_ENTRIES];
  int                     entry_count;

  logic [`BMC_BYTE_W-1:0] rsp_seen [$];  // Bytes taken from the transmit side.
  int                     seed = 37182;
  int                     check_count;
  int                     error_count;
  int                     cycle_count;

  board_ctrl_top i_board_ctrl_top (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .rx_data_i   (rx_data_i),
    .rx_strb_i   (rx_strb_i),
    .rx_busy_o   (rx_busy_o),
    .tx_data_o   (tx_data_o),
    .tx_strb_o   (tx_strb_o),
    .tx_busy_i   (tx_busy_i),
    .event_i     (event_i),
    .sys_config_o(sys_config_o),
    .irq_o       (irq_o)
  );

  initial begin
    gclk40 = 1'b0;
    forever #(CLK_PERIOD / 2) gclk40 = ~gclk40;
  end

  task automatic step_cycle();
    @(posedge gclk40);
    #DRIVE_DELAY;
  endtask

  task automatic compare_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t ns: %s is 0x%04h, expected 0x%04h",
               $time, name, actual, expected);
    end
  endtask

  function automatic logic [`BMC_ADDR_W-1:0] sysconf_addr(input sysconf_reg_e offset);
    return `BMC_SYSCONF_BASE + {{(`BMC_ADDR_W-`BMC_OFFSET_W){1'b0}}, offset};
  endfunction

  function automatic logic [`BMC_ADDR_W-1:0] irq_addr(input irq_reg_e offset);
    return `BMC_IRQ_BASE + {{(`BMC_ADDR_W-`BMC_OFFSET_W){1'b0}}, offset};
  endfunction

  function automatic logic [`BMC_DATA_W-1:0] irq_bit(input irq_src_e src);
    return 16'h0001 << src;
  endfunction

  task automatic store_expect(input logic ev, input logic [7:0] cfg, input logic irq);
    event_tab[entry_count] = ev;
    cfg_tab[entry_count]   = cfg;
    irq_tab[entry_count]   = irq;
    entry_count++;
  endtask

  task automatic add_read(input logic [15:0] addr, input logic ev, input logic [7:0] status,
                          input logic [15:0] data, input logic [7:0] cfg, input logic irq);
    req_tab[entry_count][0] = OP_READ;
    req_tab[entry_count][1] = addr[15:8];
    req_tab[entry_count][2] = addr[7:0];
    req_len[entry_count]    = 3;
    rsp_tab[entry_count][0] = status;
    rsp_tab[entry_count][1] = (status == ST_OK) ? data[15:8] : 8'h00;  // Zero on error.
    rsp_tab[entry_count][2] = (status == ST_OK) ? data[7:0] : 8'h00;
    rsp_len[entry_count]    = 3;
    store_expect(ev, cfg, irq);
  endtask

  task automatic add_write(input logic [15:0] addr, input logic [15:0] data, input logic ev,
                           input logic [7:0] status, input logic [7:0] cfg, input logic irq);
    req_tab[entry_count][0] = OP_WRITE;
    req_tab[entry_count][1] = addr[15:8];
    req_tab[entry_count][2] = addr[7:0];
    req_tab[entry_count][3] = data[15:8];
    req_tab[entry_count][4] = data[7:0];
    req_len[entry_count]    = 5;
    rsp_tab[entry_count][0] = status;  // Writes answer with the status only.
    rsp_len[entry_count]    = 1;
    store_expect(ev, cfg, irq);
  endtask

  task automatic add_bad_opcode(input logic [7:0] opcode, input logic ev,
                                input logic [7:0] cfg, input logic irq);
    req_tab[entry_count][0] = opcode;
    req_len[entry_count]    = 1;
    rsp_tab[entry_count][0] = ST_BAD_OP;
    rsp_len[entry_count]    = 1;
    store_expect(ev, cfg, irq);
  endtask

  task automatic build_table();
    add_read(sysconf_addr(BOARD_ID), 1'b0, ST_OK, `BMC_BOARD_ID, `BMC_SYS_CONFIG_RESET, 1'b0);
    add_read(sysconf_addr(REVISION), 1'b0, ST_OK, `BMC_REVISION, `BMC_SYS_CONFIG_RESET, 1'b0);
    add_write(sysconf_addr(CONFIG), 16'h00A5, 1'b0, ST_OK, 8'hA5, 1'b0);
    add_read(sysconf_addr(CONFIG), 1'b0, ST_OK, 16'h00A5, 8'hA5, 1'b0);
    add_write(sysconf_addr(SCRATCH), 16'h1234, 1'b0, ST_OK, 8'hA5, 1'b0);
    add_read(sysconf_addr(SCRATCH), 1'b0, ST_OK, 16'h1234, 8'hA5, 1'b0);
    add_write(sysconf_addr(BOARD_ID), 16'hFFFF, 1'b0, ST_OK, 8'hA5, 1'b0);  // Read-only.
    add_read(sysconf_addr(BOARD_ID), 1'b0, ST_OK, `BMC_BOARD_ID, 8'hA5, 1'b0);
    add_read(16'h0040, 1'b0, ST_BUS_ERR, 16'h0000, 8'hA5, 1'b0);  // Unmapped.
    add_read(irq_addr(STATUS), 1'b0, ST_OK, irq_bit(SRC_MEMV), 8'hA5, 1'b0);
    add_write(irq_addr(MASK), 16'h0003, 1'b0, ST_OK, 8'hA5, 1'b1);
    add_write(irq_addr(STATUS), irq_bit(SRC_MEMV), 1'b0, ST_OK, 8'hA5, 1'b0);
    add_read(irq_addr(STATUS), 1'b0, ST_OK, 16'h0000, 8'hA5, 1'b0);
    add_read(irq_addr(STATUS), 1'b1, ST_OK, irq_bit(SRC_EVENT), 8'hA5, 1'b1);
    add_write(irq_addr(STATUS), irq_bit(SRC_EVENT), 1'b1, ST_OK, 8'hA5, 1'b0);
    add_read(irq_addr(STATUS), 1'b0, ST_OK, 16'h0000, 8'hA5, 1'b0);
    add_bad_opcode(8'h7F, 1'b0, 8'hA5, 1'b0);
    add_read(sysconf_addr(CONFIG), 1'b0, ST_OK, 16'h00A5, 8'hA5, 1'b0);
    add_read(irq_addr(MASK), 1'b0, ST_OK, 16'h0003, 8'hA5, 1'b0);
  endtask

  // Called just after a drive point, leaves the strobe low at the next one.
  task automatic send_byte(input logic [7:0] data);
    while (rx_busy_o) begin
      step_cycle();
    end
    rx_data_i = data;
    rx_strb_i = 1'b1;
    step_cycle();
    rx_strb_i = 1'b0;
  endtask

  task automatic run_entry(input int idx);
    int b;
    int busy_low;
    rsp_seen.delete();
    busy_low = 0;
    if (event_i !== event_tab[idx]) begin
      event_i = event_tab[idx];
      repeat (SYNC_CYCLES) step_cycle();  // Let the level reach the status register.
    end
    for (b = 0; b < req_len[idx]; b++) begin
      send_byte(req_tab[idx][b]);
    end
    // Busy from the cycle after the last request byte until the last response byte.
    while (rsp_seen.size() < rsp_len[idx]) begin
      if (!rx_busy_o) begin
        busy_low++;
      end
      step_cycle();
    end
    compare_value($sformatf("rx_busy_o low cycles in entry %0d", idx),
                  16'(busy_low), 16'h0000);
    compare_value($sformatf("rx_busy_o after entry %0d", idx), 16'(rx_busy_o), 16'h0000);
    repeat (SETTLE_CYCLES) step_cycle();
    compare_value($sformatf("tx_strb_o count of entry %0d", idx),
                  16'(rsp_seen.size()), 16'(rsp_len[idx]));
    for (b = 0; b < rsp_len[idx] && b < rsp_seen.size(); b++) begin
      compare_value($sformatf("tx_data_o[%0d] of entry %0d", b, idx),
                    16'(rsp_seen[b]), 16'(rsp_tab[idx][b]));
    end
    compare_value($sformatf("sys_config_o after entry %0d", idx),
                  16'(sys_config_o), 16'(cfg_tab[idx]));
    compare_value($sformatf("irq_o after entry %0d", idx), 16'(irq_o), 16'(irq_tab[idx]));
  endtask

  // A byte counts once, in the cycle before the edge that takes it.
  always @(negedge gclk40) begin
    if (hard_reset && tx_strb_o) begin
      compare_value("tx_busy_i under tx_strb_o", 16'(tx_busy_i), 16'h0000);
      if (!tx_busy_i) begin
        rsp_seen.push_back(tx_data_o);  // A busy host drops the byte.
      end
    end
  end

  initial begin : busy_driver
    int draw;
    tx_busy_i = 1'b0;
    @(posedge hard_reset);
    forever begin
      step_cycle();
      draw      = $random(seed);
      tx_busy_i = (($unsigned(draw) % 32'd3) == 32'd0);  // About one cycle in three.
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge gclk40);
      cycle_count++;
    end
    $display("Timeout: the command table did not finish within %0d cycles.", TIMEOUT_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Test failed");
    $finish;
  end

  initial begin : main_sequence
    int i;
    hard_reset  = 1'b0;
    rx_data_i   = '0;
    rx_strb_i   = 1'b0;
    event_i     = 1'b0;
    check_count = 0;
    error_count = 0;
    entry_count = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge gclk40);
    #DRIVE_DELAY;
    hard_reset = 1'b1;
    compare_value("sys_config_o after reset", 16'(sys_config_o), 16'(`BMC_SYS_CONFIG_RESET));
    compare_value("irq_o after reset", 16'(irq_o), 16'h0000);
    compare_value("tx_strb_o after reset", 16'(tx_strb_o), 16'h0000);
    compare_value("rx_busy_o after reset", 16'(rx_busy_o), 16'h0000);
    if (entry_count != NUM_ENTRIES) begin
      error_count++;
      $display("The command table holds %0d entries instead of %0d.", entry_count,
               NUM_ENTRIES);
    end
    for (i = 0; i < entry_count; i++) begin
      run_entry(i);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: board_ctrl.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/board_pkg.sv
rtl/reg_bus_if.sv
rtl/as_reg_bridge.sv
rtl/reg_decoder.sv
rtl/sys_config_regs.sv
rtl/irq_controller.sv
rtl/board_ctrl_top.sv
bench/tb_board_ctrl.sv

// File: rtl/as_reg_bridge.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

module as_reg_bridge import bus_pkg::*; (
  input  logic                   gclk40,
  input  logic                   hard_reset,
  input  logic [`BMC_BYTE_W-1:0] rx_data_i,
  input  logic                   rx_strb_i,
  output logic                   rx_busy_o,
  output logic [`BMC_BYTE_W-1:0] tx_data_o,
  output logic                   tx_strb_o,
  input  logic                   tx_busy_i,
  reg_bus_if.master              bus
);

  bridge_state_e          state;
  logic                   byte_second;  // Low byte of a pair is next.
  logic                   stb_q;
  logic                   we_q;
  logic [`BMC_ADDR_W-1:0] adr_q;
  logic [`BMC_DATA_W-1:0] wdat_q;
  logic [`BMC_DATA_W-1:0] resp_data;
  bmc_status_e            resp_status;
  logic [1:0]             resp_idx;
  logic [1:0]             resp_last;
  logic                   bus_done;

  assign bus_done = bus.ack || bus.err;

  assign bus.cyc  = stb_q;  // Single transfers, so cyc and stb coincide.
  assign bus.stb  = stb_q;
  assign bus.we   = we_q;
  assign bus.adr  = adr_q;
  assign bus.wdat = wdat_q;

  assign rx_busy_o = (state == BR_BUS) || (state == BR_RESP);
  assign tx_strb_o = (state == BR_RESP) && !tx_busy_i;

  always_comb begin
    case (resp_idx)
      2'd0:    tx_data_o = resp_status;
      2'd1:    tx_data_o = resp_data[`BMC_DATA_W-1 -: `BMC_BYTE_W];
      default: tx_data_o = resp_data[`BMC_BYTE_W-1:0];
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      state       <= BR_RX_OP;
      byte_second <= 1'b0;
      stb_q       <= 1'b0;
      resp_status <= ST_OK;
      resp_idx    <= 2'd0;
      resp_last   <= 2'd0;
    end else begin
      case (state)
        BR_RX_OP: begin
          byte_second <= 1'b0;
          resp_idx    <= 2'd0;
          if (rx_strb_i) begin
            case (rx_data_i)
              OP_READ, OP_WRITE: state <= BR_RX_ADDR;
              default: begin
                resp_status <= ST_BAD_OP;  // Answer at once, no bus cycle.
                resp_last   <= 2'd0;
                state       <= BR_RESP;
              end
            endcase
          end
        end
        BR_RX_ADDR, BR_RX_DATA: begin
          if (rx_strb_i) begin
            byte_second <= !byte_second;
            if (byte_second) begin
              if (state == BR_RX_ADDR && we_q) begin
                state <= BR_RX_DATA;
              end else begin
                state <= BR_BUS;
                stb_q <= 1'b1;
              end
            end
          end
        end
        BR_BUS: begin
          if (bus_done) begin
            stb_q       <= 1'b0;
            resp_status <= bus.err ? ST_BUS_ERR : ST_OK;
            resp_last   <= we_q ? 2'd0 : 2'd2;  // Reads return two data bytes.
            state       <= BR_RESP;
          end
        end
        BR_RESP: begin
          if (!tx_busy_i) begin
            if (resp_idx == resp_last) begin
              state <= BR_RX_OP;
            end else begin
              resp_idx <= resp_idx + 2'd1;
            end
          end
        end
        default: state <= BR_RX_OP;
      endcase
    end
  end

  // Command fields shift in high byte first.
  always_ff @(posedge gclk40) begin
    if (rx_strb_i && state == BR_RX_OP) begin
      we_q <= (rx_data_i == OP_WRITE);
    end
    if (rx_strb_i && state == BR_RX_ADDR) begin
      adr_q <= {adr_q[`BMC_BYTE_W-1:0], rx_data_i};
    end
    if (rx_strb_i && state == BR_RX_DATA) begin
      wdat_q <= {wdat_q[`BMC_BYTE_W-1:0], rx_data_i};
    end
    if (state == BR_BUS && bus_done) begin
      resp_data <= bus.ack ? bus.rdat : '0;
    end
  end

  // A blocked response byte is neither strobed nor advanced.
  a_tx_hold: assert property (@(posedge gclk40) disable iff (!hard_reset)
    (state == BR_RESP && tx_busy_i) |-> !tx_strb_o ##1
      (state == BR_RESP && $stable(resp_idx)));

  // A bus cycle only starts once a request is complete.
  a_stb_rise: assert property (@(posedge gclk40) disable iff (!hard_reset)
    $rose(bus.stb) |-> $past(state) != BR_RESP && state == BR_BUS);

endmodule

// File: rtl/bmc_consts.svh
`ifndef BMC_CONSTS_SVH
`define BMC_CONSTS_SVH

// Stream and bus widths.
`define BMC_BYTE_W   8
`define BMC_ADDR_W   16
`define BMC_DATA_W   16
`define BMC_OFFSET_W 4

// Word address map of the register slaves.
`define BMC_SYSCONF_BASE 16'h0000
`define BMC_SYSCONF_HIGH 16'h000F
`define BMC_IRQ_BASE     16'h0010
`define BMC_IRQ_HIGH     16'h001F

// Board identity, major 1 minor 2.
`define BMC_BOARD_ID 16'h00B1
`define BMC_REVISION 16'h0102

// Reset values and sizes.
`define BMC_SYS_CONFIG_RESET 8'h01
`define BMC_IRQ_NUM_SOURCES  2

`endif

// File: rtl/board_ctrl_top.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

module board_ctrl_top (
  input  logic                   gclk40,
  input  logic                   hard_reset,
  input  logic [`BMC_BYTE_W-1:0] rx_data_i,
  input  logic                   rx_strb_i,
  output logic                   rx_busy_o,
  output logic [`BMC_BYTE_W-1:0] tx_data_o,
  output logic                   tx_strb_o,
  input  logic                   tx_busy_i,
  input  logic                   event_i,
  output logic [`BMC_BYTE_W-1:0] sys_config_o,
  output logic                   irq_o
);

  logic                     sysconf_sel;
  logic                     irq_sel;
  logic                     reg_we;
  logic [`BMC_OFFSET_W-1:0] reg_offset;
  logic [`BMC_DATA_W-1:0]   reg_wdat;
  logic [`BMC_DATA_W-1:0]   sysconf_rdat;
  logic [`BMC_DATA_W-1:0]   irq_rdat;
  logic                     memv;

  reg_bus_if i_reg_bus ();

  as_reg_bridge i_as_reg_bridge (
    .gclk40    (gclk40),
    .hard_reset(hard_reset),
    .rx_data_i (rx_data_i),
    .rx_strb_i (rx_strb_i),
    .rx_busy_o (rx_busy_o),
    .tx_data_o (tx_data_o),
    .tx_strb_o (tx_strb_o),
    .tx_busy_i (tx_busy_i),
    .bus       (i_reg_bus.master)
  );

  reg_decoder i_reg_decoder (
    .gclk40        (gclk40),
    .hard_reset    (hard_reset),
    .bus           (i_reg_bus.slave),
    .sysconf_sel_o (sysconf_sel),
    .irq_sel_o     (irq_sel),
    .reg_we_o      (reg_we),
    .reg_offset_o  (reg_offset),
    .reg_wdat_o    (reg_wdat),
    .sysconf_rdat_i(sysconf_rdat),
    .irq_rdat_i    (irq_rdat),
    .memv_o        (memv)
  );

  sys_config_regs i_sys_config_regs (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .sel_i       (sysconf_sel),
    .we_i        (reg_we),
    .offset_i    (reg_offset),
    .wdat_i      (reg_wdat),
    .rdat_o      (sysconf_rdat),
    .sys_config_o(sys_config_o)
  );

  irq_controller i_irq_controller (
    .gclk40    (gclk40),
    .hard_reset(hard_reset),
    .sel_i     (irq_sel),
    .we_i      (reg_we),
    .offset_i  (reg_offset),
    .wdat_i    (reg_wdat),
    .rdat_o    (irq_rdat),
    .memv_i    (memv),  // Unmapped accesses raise an interrupt.
    .event_i   (event_i),
    .irq_o     (irq_o)
  );

endmodule

// File: rtl/board_pkg.sv
`include "bmc_consts.svh"

package board_pkg;

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_SYSCONF,
    REGION_IRQ
  } region_e;

  // Word offsets inside each region.
  typedef enum logic [`BMC_OFFSET_W-1:0] {
    BOARD_ID = 4'd0,
    REVISION = 4'd1,
    CONFIG   = 4'd2,
    SCRATCH  = 4'd3
  } sysconf_reg_e;

  typedef enum logic [`BMC_OFFSET_W-1:0] {
    STATUS = 4'd0,
    MASK   = 4'd1
  } irq_reg_e;

  typedef enum int unsigned {
    SRC_MEMV  = 0,
    SRC_EVENT = 1
  } irq_src_e;

endpackage

// File: rtl/bus_pkg.sv
`include "bmc_consts.svh"

package bus_pkg;

  // Host opcodes, first byte of every command.
  typedef enum logic [`BMC_BYTE_W-1:0] {
    OP_READ  = 8'h01,
    OP_WRITE = 8'h02
  } bmc_op_e;

  // Status byte, first byte of every response.
  typedef enum logic [`BMC_BYTE_W-1:0] {
    ST_OK      = 8'h00,
    ST_BUS_ERR = 8'h01,
    ST_BAD_OP  = 8'h02
  } bmc_status_e;

  typedef enum logic [2:0] {
    BR_RX_OP,    // Waiting for an opcode.
    BR_RX_ADDR,  // Two address bytes, high first.
    BR_RX_DATA,  // Two write data bytes, high first.
    BR_BUS,      // One bus cycle in flight.
    BR_RESP      // Serializing the response.
  } bridge_state_e;

endpackage

// File: rtl/irq_controller.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

module irq_controller import board_pkg::*; (
  input  logic                     gclk40,
  input  logic                     hard_reset,
  input  logic                     sel_i,
  input  logic                     we_i,
  input  logic [`BMC_OFFSET_W-1:0] offset_i,
  input  logic [`BMC_DATA_W-1:0]   wdat_i,
  output logic [`BMC_DATA_W-1:0]   rdat_o,
  input  logic                     memv_i,
  input  logic                     event_i,
  output logic                     irq_o
);

  logic [2:0]                      event_pipe;  // Two sync flops and the edge flop.
  logic                            event_rise;
  logic [`BMC_IRQ_NUM_SOURCES-1:0] src_set;
  logic [`BMC_IRQ_NUM_SOURCES-1:0] src_clr;
  logic [`BMC_IRQ_NUM_SOURCES-1:0] status_q;
  logic [`BMC_IRQ_NUM_SOURCES-1:0] mask_q;
  logic                            irq_q;

  assign event_rise = event_pipe[1] && !event_pipe[2];

  always_comb begin
    src_set            = '0;
    src_set[SRC_MEMV]  = memv_i;
    src_set[SRC_EVENT] = event_rise;
  end

  // Write one to clear.
  assign src_clr = (sel_i && we_i && offset_i == STATUS) ?
                   wdat_i[`BMC_IRQ_NUM_SOURCES-1:0] : '0;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      event_pipe <= '0;
      status_q   <= '0;
      mask_q     <= '0;
      irq_q      <= 1'b0;
    end else begin
      event_pipe <= {event_pipe[1:0], event_i};
      status_q   <= (status_q & ~src_clr) | src_set;  // Set wins over clear.
      if (sel_i && we_i && offset_i == MASK) begin
        mask_q <= wdat_i[`BMC_IRQ_NUM_SOURCES-1:0];
      end
      irq_q <= |(status_q & mask_q);
    end
  end

  always_comb begin
    case (offset_i)
      STATUS:  rdat_o = {{(`BMC_DATA_W-`BMC_IRQ_NUM_SOURCES){1'b0}}, status_q};
      MASK:    rdat_o = {{(`BMC_DATA_W-`BMC_IRQ_NUM_SOURCES){1'b0}}, mask_q};
      default: rdat_o = '0;
    endcase
  end

  assign irq_o = irq_q;

  a_irq_masked: assert property (@(posedge gclk40) disable iff (!hard_reset)
    (mask_q == '0) |=> !irq_o);

endmodule

// File: rtl/reg_bus_if.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

interface reg_bus_if;

  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [`BMC_ADDR_W-1:0] adr;
  logic [`BMC_DATA_W-1:0] wdat;
  logic [`BMC_DATA_W-1:0] rdat;
  logic                   ack;  // Exactly one of ack and err ends a cycle.
  logic                   err;

  modport master (
    output cyc, stb, we, adr, wdat,
    input  rdat, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, wdat,
    output rdat, ack, err
  );

endinterface

// File: rtl/reg_decoder.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

module reg_decoder import board_pkg::*; (
  input  logic                     gclk40,
  input  logic                     hard_reset,
  reg_bus_if.slave                 bus,
  output logic                     sysconf_sel_o,
  output logic                     irq_sel_o,
  output logic                     reg_we_o,
  output logic [`BMC_OFFSET_W-1:0] reg_offset_o,
  output logic [`BMC_DATA_W-1:0]   reg_wdat_o,
  input  logic [`BMC_DATA_W-1:0]   sysconf_rdat_i,
  input  logic [`BMC_DATA_W-1:0]   irq_rdat_i,
  output logic                     memv_o
);

  region_e                region;
  logic                   access;
  logic                   ack_q;
  logic                   err_q;
  logic [`BMC_DATA_W-1:0] rdat_q;

  function automatic logic in_range(
    input logic [`BMC_ADDR_W-1:0] addr,
    input logic [`BMC_ADDR_W-1:0] low,
    input logic [`BMC_ADDR_W-1:0] high
  );
    return (addr >= low) && (addr <= high);
  endfunction

  always_comb begin
    if (in_range(bus.adr, `BMC_SYSCONF_BASE, `BMC_SYSCONF_HIGH)) begin
      region = REGION_SYSCONF;
    end else if (in_range(bus.adr, `BMC_IRQ_BASE, `BMC_IRQ_HIGH)) begin
      region = REGION_IRQ;
    end else begin
      region = REGION_NONE;
    end
  end

  // First cycle of stb only, the master still holds it while ack is up.
  assign access = bus.cyc && bus.stb && !ack_q && !err_q;

  assign sysconf_sel_o = access && (region == REGION_SYSCONF);
  assign irq_sel_o     = access && (region == REGION_IRQ);
  assign reg_we_o      = bus.we;
  assign reg_offset_o  = bus.adr[`BMC_OFFSET_W-1:0];
  assign reg_wdat_o    = bus.wdat;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access && (region != REGION_NONE);
      err_q <= access && (region == REGION_NONE);  // Memory violation.
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      case (region)
        REGION_SYSCONF: rdat_q <= sysconf_rdat_i;
        REGION_IRQ:     rdat_q <= irq_rdat_i;
        default:        rdat_q <= '0;
      endcase
    end
  end

  assign bus.ack  = ack_q;
  assign bus.err  = err_q;
  assign bus.rdat = rdat_q;
  assign memv_o   = err_q;

  // One slave at a time, and every select is acknowledged next cycle.
  a_sel_ack: assert property (@(posedge gclk40) disable iff (!hard_reset)
    (sysconf_sel_o || irq_sel_o) |-> !(sysconf_sel_o && irq_sel_o) ##1
      (bus.ack && !bus.err));

endmodule

// File: rtl/sys_config_regs.sv
`timescale 1ns/100ps
`include "bmc_consts.svh"

module sys_config_regs import board_pkg::*; (
  input  logic                     gclk40,
  input  logic                     hard_reset,
  input  logic                     sel_i,
  input  logic                     we_i,
  input  logic [`BMC_OFFSET_W-1:0] offset_i,
  input  logic [`BMC_DATA_W-1:0]   wdat_i,
  output logic [`BMC_DATA_W-1:0]   rdat_o,
  output logic [`BMC_BYTE_W-1:0]   sys_config_o
);

  logic [`BMC_BYTE_W-1:0] config_q;
  logic [`BMC_DATA_W-1:0] scratch_q;
  logic                   wr;

  assign wr = sel_i && we_i;

  // Identity registers ignore writes.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      config_q  <= `BMC_SYS_CONFIG_RESET;
      scratch_q <= '0;
    end else if (wr) begin
      if (offset_i == CONFIG) begin
        config_q <= wdat_i[`BMC_BYTE_W-1:0];  // Upper byte dropped.
      end
      if (offset_i == SCRATCH) begin
        scratch_q <= wdat_i;
      end
    end
  end

  always_comb begin
    case (offset_i)
      BOARD_ID: rdat_o = `BMC_BOARD_ID;
      REVISION: rdat_o = `BMC_REVISION;
      CONFIG:   rdat_o = {{(`BMC_DATA_W-`BMC_BYTE_W){1'b0}}, config_q};
      SCRATCH:  rdat_o = scratch_q;
      default:  rdat_o = '0;
    endcase
  end

  assign sys_config_o = config_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the board controller testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_board_ctrl -f board_ctrl.f -o sim_board_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

sim_out=$(./obj_dir/sim_board_ctrl)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
echo "Pass message not found in the simulation output."
exit 1
